// File: lms_to_oklab.f
source/oklab_pkg.sv
source/cube_root_pipe.sv
source/oklab_matrix.sv
source/oklab_round_clamp.sv
source/sync_delay.sv
source/lms_to_oklab.sv
dv/oklab_checker.sv
dv/oklab_asserts.sv
dv/tb_lms_to_oklab.sv

// File: Bender.yml
package:
  name: lms_to_oklab

sources:
  - source/oklab_pkg.sv
  - source/cube_root_pipe.sv
  - source/oklab_matrix.sv
  - source/oklab_round_clamp.sv
  - source/sync_delay.sv
  - source/lms_to_oklab.sv
  - target: test
    files:
      - dv/oklab_checker.sv
      - dv/oklab_asserts.sv
      - dv/tb_lms_to_oklab.sv

// File: dv/tb_lms_to_oklab.sv
// ====================
// Testbench top for the LMS to OKLab converter.
// Runs corner, saturation, random and line strobe tests through the
// DUT; the checker module does all comparing.
// ====================

`timescale 1ns/1ps

module tb_lms_to_oklab import oklab_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 2000;
    localparam int N_LINES      = 3;
    localparam int HREF_CYCLES  = 64;
    // hstr, href run, hend, then a short gap
    localparam int LINE_CYCLES  = HREF_CYCLES + 6;
    localparam int RUN_CYCLES   = RESET_CYCLES + 64 + N_RANDOM + N_LINES * LINE_CYCLES
                                  + 4 * PIPE_LAT;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 640;

    // Test tags seen by the checker
    localparam logic [3:0] T_RESET  = 4'd0;
    localparam logic [3:0] T_CORNER = 4'd1;
    localparam logic [3:0] T_SAT    = 4'd2;
    localparam logic [3:0] T_RANDOM = 4'd3;
    localparam logic [3:0] T_SYNC   = 4'd4;

    logic        clk = 1'b0;
    logic        rst_n;
    lms_t        i_lms;
    sync_t       i_sync;
    oklab_t      o_lab;
    sync_t       o_sync;
    logic [3:0]  test_id;
    logic [15:0] lfsr_state = 16'd89;
    int          cycle_cnt = 0;
    int          errors;
    int          checked;

    always #20 clk = ~clk;

    lms_to_oklab i_lms_to_oklab (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_lms  (i_lms),
        .i_sync (i_sync),
        .o_lab  (o_lab),
        .o_sync (o_sync)
    );

    oklab_checker i_oklab_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_test_id  (test_id),
        .i_lms      (i_lms),
        .i_sync     (i_sync),
        .i_lab      (o_lab),
        .i_lab_sync (o_sync),
        .o_errors   (errors),
        .o_checked  (checked)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_lms(output lms_t v);
        v = '0;
        for (int i = 0; i < 3 * LMS_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[3*LMS_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_sample(input logic [3:0] id, input lms_t lms, input sync_t sync);
        @(posedge clk);
        #2;
        test_id = id;
        i_lms   = lms;
        i_sync  = sync;
    endtask

    task automatic drive_idle(input logic [3:0] id, input int n);
        repeat (n) begin
            drive_sample(id, '0, '0);
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        lms_t px;
        int   assert_fails;
        rst_n   = 1'b1;
        i_lms   = '0;
        i_sync  = '0;
        test_id = T_RESET;
        // Async reset edge just after time zero
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Zeros until the first real sample
        drive_idle(T_RESET, 8);

        drive_sample(T_CORNER, {12'd0, 12'd0, 12'd0}, '0);
        drive_sample(T_CORNER, {12'd16, 12'd0, 12'd0}, '0);
        drive_sample(T_CORNER, {12'd0, 12'd16, 12'd0}, '0);
        drive_sample(T_CORNER, {12'd0, 12'd0, 12'd16}, '0);
        drive_sample(T_CORNER, {12'd16, 12'd16, 12'd16}, '0);

        drive_sample(T_SAT, {12'd4095, 12'd4095, 12'd4095}, '0);
        drive_sample(T_SAT, {12'd0, 12'd4095, 12'd0}, '0);
        drive_sample(T_SAT, {12'd0, 12'd0, 12'd4095}, '0);
        drive_sample(T_SAT, {12'd4095, 12'd0, 12'd0}, '0);
        drive_idle(T_SAT, PIPE_LAT);

        // Back to back, many samples in flight
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_lms(px);
            drive_sample(T_RANDOM, px, '0);
        end

        for (int n = 0; n < N_LINES; n++) begin
            draw_lms(px);
            drive_sample(T_SYNC, px, 3'b100);
            for (int i = 0; i < HREF_CYCLES; i++) begin
                draw_lms(px);
                drive_sample(T_SYNC, px, 3'b010);
            end
            draw_lms(px);
            drive_sample(T_SYNC, px, 3'b001);
            drive_idle(T_SYNC, 4);
        end

        // Flush the pipeline
        drive_idle(T_SYNC, PIPE_LAT + 2);
        @(negedge clk);
        #1;
        assert_fails = i_lms_to_oklab.i_oklab_asserts.fail_cnt;
        i_oklab_checker.report(assert_fails);
        if (errors == 0 && checked > 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            if (checked == 0) begin
                $display("No samples were compared against the reference");
            end
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// File: dv/oklab_asserts.sv
// ====================
// Concurrent checks bound into the LMS to OKLab top level.
// Covers reset values and strobe alignment through the pipeline.
// ====================

`timescale 1ns/1ps

module oklab_asserts import oklab_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input sync_t  i_sync,
    input oklab_t o_lab,
    input sync_t  o_sync
);

    // Failed assertion count
    int fail_cnt = 0;

    // Outputs idle while reset is held
    a_reset_zero: assert property (@(posedge clk) !rst_n |-> (o_lab == '0 && o_sync == '0))
        else begin
            fail_cnt++;
            $error("outputs not zero during reset");
        end

    // Strobes leave exactly PIPE_LAT clocks after they enter
    a_sync_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n, PIPE_LAT) |-> o_sync == $past(i_sync, PIPE_LAT))
        else begin
            fail_cnt++;
            $error("o_sync does not match i_sync from PIPE_LAT cycles earlier");
        end

endmodule

bind lms_to_oklab oklab_asserts i_oklab_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_sync (i_sync),
    .o_lab  (o_lab),
    .o_sync (o_sync)
);

// File: dv/oklab_checker.sv
// ====================
// Scoreboard for the LMS to OKLab pipeline.
// Samples the DUT inputs on every rising edge, queues the expected
// output, and compares it on the falling edge PIPE_LAT clocks later.
// ====================

`timescale 1ns/1ps

module oklab_checker import oklab_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_test_id,
    input  lms_t       i_lms,
    input  sync_t      i_sync,
    input  oklab_t     i_lab,
    input  sync_t      i_lab_sync,
    output int         o_errors,
    output int         o_checked
);

    // One queued expectation, tagged with the test that made it
    typedef struct packed {
        logic [3:0] test_id;
        oklab_t     lab;
        sync_t      sync;
    } expect_t;

    expect_t exp_q [$];
    int      lab_errors   = 0;
    int      sync_errors  = 0;
    int      reset_errors = 0;
    int      checked      = 0;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd0:    return "reset";
            4'd1:    return "corner";
            4'd2:    return "saturation";
            4'd3:    return "random";
            4'd4:    return "sync";
            default: return "idle";
        endcase
    endfunction

    // Largest r with r^3 <= rad
    function automatic longint cube_root_floor(input longint rad);
        longint r;
        // Float estimate, then walk to the exact floor
        r = longint'($floor($pow(real'(rad), 1.0 / 3.0)));
        while (r > 0 && r * r * r > rad) begin
            r--;
        end
        while ((r + 1) * (r + 1) * (r + 1) <= rad) begin
            r++;
        end
        return r;
    endfunction

    // Round half up, arithmetic shift
    function automatic longint round_shift(input longint v, input int sh);
        return (v + (longint'(1) << (sh - 1))) >>> sh;
    endfunction

    function automatic longint clamp(input longint v, input longint lo, input longint hi);
        if (v < lo) begin
            return lo;
        end
        if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    // Expected OKLab for one LMS sample
    function automatic oklab_t reference(input lms_t lms);
        longint rl;
        longint rm;
        longint rs;
        longint vl;
        longint va;
        longint vb;
        oklab_t lab;
        rl = cube_root_floor(longint'(lms.l) << ROOT_PRE_SHIFT);
        rm = cube_root_floor(longint'(lms.m) << ROOT_PRE_SHIFT);
        rs = cube_root_floor(longint'(lms.s) << ROOT_PRE_SHIFT);
        // Matrix rows, 22 fraction bits
        vl = round_shift(C_LL * rl + C_LM * rm + C_LS * rs, L_SHIFT);
        va = round_shift(C_AL * rl + C_AM * rm + C_AS * rs, AB_SHIFT);
        vb = round_shift(C_BL * rl + C_BM * rm + C_BS * rs, AB_SHIFT);
        vl = clamp(vl, 0, 32767);
        va = clamp(va, -8192, 8191);
        vb = clamp(vb, -8192, 8191);
        lab.l = vl[L_W-1:0];
        lab.a = va[AB_W-1:0];
        lab.b = vb[AB_W-1:0];
        return lab;
    endfunction

    // ====================
    // Capture and compare
    // ====================
    always @(posedge clk) begin
        if (rst_n) begin
            exp_q.push_back({i_test_id, reference(i_lms), i_sync});
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (!rst_n || exp_q.size() < PIPE_LAT) begin
            // Nothing in flight yet, outputs still from reset
            if (i_lab !== '0 || i_lab_sync !== '0) begin
                reset_errors++;
                $display("Error [reset] expected lab 0 sync 000, actual lab %h sync %b",
                         i_lab, i_lab_sync);
            end
        end else begin
            e = exp_q.pop_front();
            checked++;
            if (i_lab !== e.lab) begin
                lab_errors++;
                $display("Error [%s] expected L=%0d a=%0d b=%0d, actual L=%0d a=%0d b=%0d",
                         test_name(e.test_id), e.lab.l, e.lab.a, e.lab.b,
                         i_lab.l, i_lab.a, i_lab.b);
            end
            if (i_lab_sync !== e.sync) begin
                sync_errors++;
                $display("Error [%s] expected sync %b, actual sync %b",
                         test_name(e.test_id), e.sync, i_lab_sync);
            end
        end
    end

    assign o_errors  = lab_errors + sync_errors + reset_errors;
    assign o_checked = checked;

    // Closing summary line
    task automatic report(input int assert_errors);
        $display("Checked %0d samples, errors lab %0d sync %0d reset %0d assert %0d",
                 checked, lab_errors, sync_errors, reset_errors, assert_errors);
    endtask

endmodule

// File: source/lms_to_oklab.sv
// ====================
// LMS to OKLab converter, top level.
// Takes one 8.4 LMS sample per clock with its line strobes and
// returns L (0.15), a and b (S1.13) PIPE_LAT clocks later, strobes
// aligned. No handshake, data moves every cycle.
// ====================

`timescale 1ns/1ps

module lms_to_oklab import oklab_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  lms_t   i_lms,
    input  sync_t  i_sync,
    output oklab_t o_lab,
    output sync_t  o_sync
);

    // Roots out of the cube root front end
    root_t root;
    // Unrounded matrix sums
    mix_t  mix;

    // ====================
    // Cube roots, one per channel
    // ====================
    cube_root_pipe i_cube_root_l (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_radicand (i_lms.l),
        .o_root     (root.l)
    );

    cube_root_pipe i_cube_root_m (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_radicand (i_lms.m),
        .o_root     (root.m)
    );

    cube_root_pipe i_cube_root_s (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_radicand (i_lms.s),
        .o_root     (root.s)
    );

    // ====================
    // Matrix and output stage
    // ====================
    oklab_matrix i_oklab_matrix (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_root (root),
        .o_mix  (mix)
    );

    oklab_round_clamp i_oklab_round_clamp (
        .clk   (clk),
        .rst_n (rst_n),
        .i_mix (mix),
        .o_lab (o_lab)
    );

    // Strobes follow the full datapath latency
    sync_delay i_sync_delay (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_sync (i_sync),
        .o_sync (o_sync)
    );

endmodule

// File: source/sync_delay.sv
// ====================
// Delay line for the hstr, href and hend strobes.
// PIPE_LAT registers deep, so the flags leave together with the
// pixel they were sampled with.
// ====================

`timescale 1ns/1ps

module sync_delay import oklab_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  sync_t i_sync,
    output sync_t o_sync
);

    // Tap 0 is the newest entry
    sync_t line_q [PIPE_LAT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_LAT; i++) begin
                line_q[i] <= '0;
            end
        end else begin
            line_q[0] <= i_sync;
            for (int i = 1; i < PIPE_LAT; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    assign o_sync = line_q[PIPE_LAT-1];

endmodule

// File: source/oklab_round_clamp.sv
// ====================
// Output stage of the OKLab pipeline.
// Rounds half up, drops the extra fraction bits and saturates:
// L to unsigned 0.15, a and b to signed 1.13. One clock.
// ====================

`timescale 1ns/1ps

module oklab_round_clamp import oklab_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  mix_t   i_mix,
    output oklab_t o_lab
);

    logic signed [MIX_W-1:0] l_sh;
    logic signed [MIX_W-1:0] a_sh;
    logic signed [MIX_W-1:0] b_sh;
    oklab_t                  lab_nxt;

    // Add half an LSB then arithmetic shift
    function automatic logic signed [MIX_W-1:0] rnd_shift(
        input logic signed [MIX_W-1:0] val,
        input int                      sh
    );
        logic signed [MIX_W-1:0] half;
        half = MIX_W'(1) <<< (sh - 1);
        return (val + half) >>> sh;
    endfunction

    // Saturate to 0..32767
    function automatic logic [L_W-1:0] clamp_l(input logic signed [MIX_W-1:0] val);
        if (val < 0) begin
            return '0;
        end
        if (val > L_MAX) begin
            return L_W'(L_MAX);
        end
        return val[L_W-1:0];
    endfunction

    // Saturate to -8192..8191
    function automatic logic signed [AB_W-1:0] clamp_ab(input logic signed [MIX_W-1:0] val);
        if (val < AB_MIN) begin
            return AB_W'(AB_MIN);
        end
        if (val > AB_MAX) begin
            return AB_W'(AB_MAX);
        end
        return val[AB_W-1:0];
    endfunction

    assign l_sh = rnd_shift(i_mix.l, L_SHIFT);
    assign a_sh = rnd_shift(i_mix.a, AB_SHIFT);
    assign b_sh = rnd_shift(i_mix.b, AB_SHIFT);

    assign lab_nxt.l = clamp_l(l_sh);
    assign lab_nxt.a = clamp_ab(a_sh);
    assign lab_nxt.b = clamp_ab(b_sh);

    // Registered output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_lab <= '0;
        end else begin
            o_lab <= lab_nxt;
        end
    end

endmodule

// File: source/oklab_matrix.sv
// ====================
// LMS' to Lab coefficient matrix.
// First clock registers the nine signed products of root by
// coefficient, second clock registers the three row sums. Sums keep
// 22 fraction bits for the output stage.
// ====================

`timescale 1ns/1ps

module oklab_matrix import oklab_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  root_t i_root,
    output mix_t  o_mix
);

    // Products, row major
    // 0..2 feed L, 3..5 feed a, 6..8 feed b
    logic signed [MIX_W-1:0] prod_q [9];

    // Unsigned root times signed coefficient
    function automatic logic signed [MIX_W-1:0] scale(
        input logic [ROOT_W-1:0] root,
        input int                coef
    );
        logic signed [ROOT_W:0] root_s;
        root_s = $signed({1'b0, root});
        return MIX_W'(root_s * coef);
    endfunction

    // ====================
    // Stage 1, products
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 9; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            // L row
            prod_q[0] <= scale(i_root.l, C_LL);
            prod_q[1] <= scale(i_root.m, C_LM);
            prod_q[2] <= scale(i_root.s, C_LS);
            // a row
            prod_q[3] <= scale(i_root.l, C_AL);
            prod_q[4] <= scale(i_root.m, C_AM);
            prod_q[5] <= scale(i_root.s, C_AS);
            // b row
            prod_q[6] <= scale(i_root.l, C_BL);
            prod_q[7] <= scale(i_root.m, C_BM);
            prod_q[8] <= scale(i_root.s, C_BS);
        end
    end

    // ====================
    // Stage 2, row sums
    // ====================
    // Worst case magnitude stays well below 2^29
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mix <= '0;
        end else begin
            o_mix.l <= prod_q[0] + prod_q[1] + prod_q[2];
            o_mix.a <= prod_q[3] + prod_q[4] + prod_q[5];
            o_mix.b <= prod_q[6] + prod_q[7] + prod_q[8];
        end
    end

endmodule

// File: source/cube_root_pipe.sv
// ====================
// Pipelined integer cube root for one colour channel.
// Returns floor(cbrt(x * 2^29)) as a 3.11 value, one root bit per
// stage from the MSB down. Accepts a new sample on every clock and
// delivers its root DECODE_LAT clocks later.
// ====================

`timescale 1ns/1ps

module cube_root_pipe import oklab_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [LMS_W-1:0]  i_radicand,
    output logic [ROOT_W-1:0] o_root
);

    // One stage per root bit, stage s resolves bit ROOT_W-1-s
    for (genvar s = 0; s < ROOT_W; s++) begin : g_stage
        logic [RAD_W-1:0]  rad_in;
        logic [ROOT_W-1:0] root_in;
        logic [ROOT_W-1:0] trial;
        logic [CUBE_W-1:0] trial_w;
        logic [CUBE_W-1:0] cube;
        logic [ROOT_W-1:0] root_q;

        // Stage inputs
        if (s == 0) begin : g_first
            // Scale 8.4 input so the root comes out in 3.11
            assign rad_in  = {i_radicand, {ROOT_PRE_SHIFT{1'b0}}};
            assign root_in = '0;
        end else begin : g_next
            assign rad_in  = g_stage[s-1].g_carry.rad_q;
            assign root_in = g_stage[s-1].root_q;
        end

        // Trial value with this stage's bit set
        assign trial   = root_in | (ROOT_W'(1) << (ROOT_W - 1 - s));
        assign trial_w = CUBE_W'(trial);
        // Full width cube, cannot overflow CUBE_W
        assign cube    = trial_w * trial_w * trial_w;

        // Keep the bit only if the cube still fits under the radicand
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                root_q <= '0;
            end else begin
                root_q <= (cube <= CUBE_W'(rad_in)) ? trial : root_in;
            end
        end

        // Radicand rides along, not needed past the last stage
        if (s < ROOT_W - 1) begin : g_carry
            logic [RAD_W-1:0] rad_q;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    rad_q <= '0;
                end else begin
                    rad_q <= rad_in;
                end
            end
        end
    end

    // Fully resolved root
    assign o_root = g_stage[ROOT_W-1].root_q;

endmodule

// File: source/oklab_pkg.sv
// ====================
// Shared formats, latencies, coefficients and bus types for the
// LMS to OKLab pipeline. Every RTL module pulls this in with a
// wildcard import in its header.
// ====================

package oklab_pkg;

    // ====================
    // Number formats
    // ====================
    // Input channel, unsigned 8.4
    localparam int LMS_W    = 12;
    localparam int LMS_FRAC = 4;
    // Cube root, unsigned 3.11
    localparam int ROOT_W    = 14;
    localparam int ROOT_FRAC = 11;
    // Radicand scaled so the root lands on 11 fraction bits
    localparam int ROOT_PRE_SHIFT = 3 * ROOT_FRAC - LMS_FRAC;
    localparam int RAD_W          = LMS_W + ROOT_PRE_SHIFT;
    // Trial cubes need three root widths
    localparam int CUBE_W = 3 * ROOT_W;

    // Matrix coefficients carry 11 fraction bits
    localparam int COEF_FRAC = 11;
    // Signed row sums, 22 fraction bits
    localparam int MIX_W = 30;

    // Output formats. L is 0.15, a and b are S1.13
    localparam int L_W      = 15;
    localparam int AB_W     = 14;
    localparam int L_SHIFT  = ROOT_FRAC + COEF_FRAC - L_W;
    localparam int AB_SHIFT = ROOT_FRAC + COEF_FRAC - (AB_W - 1);
    localparam int L_MAX    = (1 << L_W) - 1;
    localparam int AB_MAX   = (1 << (AB_W - 1)) - 1;
    localparam int AB_MIN   = -(1 << (AB_W - 1));

    // ====================
    // OKLab matrix, x2048
    // ====================
    localparam int C_LL = 431;
    localparam int C_LM = 1625;
    localparam int C_LS = -8;
    localparam int C_AL = 4051;
    localparam int C_AM = -4974;
    localparam int C_AS = 923;
    localparam int C_BL = 53;
    localparam int C_BM = 1603;
    localparam int C_BS = -1656;

    // Stage latencies in clocks
    localparam int DECODE_LAT  = 14;
    localparam int EXECUTE_LAT = 2;
    localparam int RESULT_LAT  = 1;
    localparam int PIPE_LAT    = DECODE_LAT + EXECUTE_LAT + RESULT_LAT;

    // ====================
    // Bus types
    // ====================
    typedef struct packed {
        logic [LMS_W-1:0] l;
        logic [LMS_W-1:0] m;
        logic [LMS_W-1:0] s;
    } lms_t;

    typedef struct packed {
        logic [ROOT_W-1:0] l;
        logic [ROOT_W-1:0] m;
        logic [ROOT_W-1:0] s;
    } root_t;

    // Raw row sums before rounding
    typedef struct packed {
        logic signed [MIX_W-1:0] l;
        logic signed [MIX_W-1:0] a;
        logic signed [MIX_W-1:0] b;
    } mix_t;

    typedef struct packed {
        logic        [L_W-1:0]  l;
        logic signed [AB_W-1:0] a;
        logic signed [AB_W-1:0] b;
    } oklab_t;

    // Line strobes, same order as the sensor interface
    typedef struct packed {
        logic hstr;
        logic href;
        logic hend;
    } sync_t;

endpackage
